//--- hw/mipsCore_macros.svh
// Sizing constants for the three-stage integer core
// Queue depth sets the source's starting credits, retire credits
// set how many retires the consumer can absorb

`ifndef MIPS_CORE_MACROS_SVH
`define MIPS_CORE_MACROS_SVH

// Input queue slots, equal to the source's credits after reset
`define QUEUE_DEPTH 4

// Retire slots held by the consumer after reset
`define RETIRE_CREDITS 2

`endif

//--- hw/mipsCorePkg.sv
// Shared types for the integer core
// Width typedefs and the decoded operation set

package mipsCorePkg;

    typedef logic [31:0] instrWord_t;
    typedef logic [4:0]  regAddr_t;
    typedef logic [31:0] regData_t;
    typedef logic [31:0] pc_t;
    typedef logic [4:0]  shamt_t;

    // One name per supported instruction
    typedef enum logic [4:0] {
        opNop,
        opAddu,
        opSubu,
        opAnd,
        opOr,
        opXor,
        opNor,
        opSlt,
        opSltu,
        opSll,
        opSrl,
        opSra,
        opAddiu,
        opAndi,
        opOri,
        opXori,
        opSlti,
        opSltiu,
        opLui,
        opBeq,
        opBne,
        opBlez,
        opBgtz,
        opBltz,
        opBgez,
        opJal
    } aluOp_t;

endpackage

//--- hw/instrDecode.sv
// Instruction decoder
// Splits a MIPS word into fields, maps it to an operation,
// picks the destination register and extends the immediate

module instrDecode import mipsCorePkg::*; (
    input  instrWord_t instrWord,
    output aluOp_t     op,
    output regAddr_t   rs,
    output regAddr_t   rt,
    output regAddr_t   dest,
    output shamt_t     shamt,
    output regData_t   imm
);

    logic [5:0]  opcode;
    logic [5:0]  funct;
    logic [15:0] imm16;
    regAddr_t    rd;

    assign opcode = instrWord[31:26];
    assign rs     = instrWord[25:21];
    assign rt     = instrWord[20:16];
    assign rd     = instrWord[15:11];
    assign shamt  = instrWord[10:6];
    assign funct  = instrWord[5:0];
    assign imm16  = instrWord[15:0];

    // Operation lookup
    always_comb begin
        op = opNop;
        if (instrWord == '0) begin
            op = opNop;
        end else if (opcode == 6'b000000) begin
            case (funct)
                6'b100001: op = opAddu;
                6'b100011: op = opSubu;
                6'b100100: op = opAnd;
                6'b100101: op = opOr;
                6'b100110: op = opXor;
                6'b100111: op = opNor;
                6'b101010: op = opSlt;
                6'b101011: op = opSltu;
                6'b000000: op = opSll;
                6'b000010: op = opSrl;
                6'b000011: op = opSra;
                default:   op = opNop;
            endcase
        end else if (opcode == 6'b000001) begin
            // Regimm group, selected by rt
            case (rt)
                5'b00000: op = opBltz;
                5'b00001: op = opBgez;
                default:  op = opNop;
            endcase
        end else begin
            case (opcode)
                6'b001001: op = opAddiu;
                6'b001100: op = opAndi;
                6'b001101: op = opOri;
                6'b001110: op = opXori;
                6'b001010: op = opSlti;
                6'b001011: op = opSltiu;
                6'b001111: op = opLui;
                6'b000100: op = opBeq;
                6'b000101: op = opBne;
                6'b000110: op = opBlez;
                6'b000111: op = opBgtz;
                6'b000011: op = opJal;
                default:   op = opNop;
            endcase
        end
    end

    // Destination, zero for branches and no-ops
    always_comb begin
        case (op)
            opAddu, opSubu, opAnd, opOr, opXor, opNor,
            opSlt, opSltu, opSll, opSrl, opSra:          dest = rd;
            opAddiu, opAndi, opOri, opXori,
            opSlti, opSltiu, opLui:                      dest = rt;
            opJal:                                       dest = 5'd31;
            default:                                     dest = '0;
        endcase
    end

    // Logic immediates are zero extended, lui goes to the upper half
    always_comb begin
        case (op)
            opAndi, opOri, opXori: imm = {16'b0, imm16};
            opLui:                 imm = {imm16, 16'b0};
            default:               imm = {{16{imm16[15]}}, imm16};
        endcase
    end

endmodule

//--- hw/regFile.sv
// General purpose register file
// 32 registers, two combinational read ports with write bypass,
// one synchronous write port, register 0 reads as zero

module regFile import mipsCorePkg::*; (
    input  logic     clk,
    input  logic     rstN,
    input  regAddr_t rdAddrA,
    input  regAddr_t rdAddrB,
    output regData_t rdDataA,
    output regData_t rdDataB,
    input  logic     regWrite,
    input  regAddr_t wrAddr,
    input  regData_t wrData
);

    regData_t regs [32];

    // Architectural registers start at zero
    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (regWrite && wrAddr != '0) begin
            regs[wrAddr] <= wrData;
        end
    end

    assign rdDataA = (rdAddrA == '0) ? '0 :
                     (regWrite && wrAddr == rdAddrA) ? wrData : regs[rdAddrA];
    assign rdDataB = (rdAddrB == '0) ? '0 :
                     (regWrite && wrAddr == rdAddrB) ? wrData : regs[rdAddrB];

    // Write-back filters out register 0 upstream
    assert property (@(posedge clk) disable iff (!rstN) regWrite |-> wrAddr != '0)
        else $error("Register write to address 0");

endmodule

//--- hw/decodeStage.sv
// Decode stage
// Credit-controlled input queue, instruction decode, operand
// read with forwarding, branch compare and the decode register

`include "mipsCore_macros.svh"

module decodeStage import mipsCorePkg::*; (
    input  logic       clk,
    input  logic       rstN,
    input  logic       instrValid,
    input  instrWord_t instrWord,
    input  pc_t        instrPc,
    output logic       instrCreditReturn,
    input  logic       stall,
    output regAddr_t   rdAddrA,
    output regAddr_t   rdAddrB,
    input  regData_t   rdDataA,
    input  regData_t   rdDataB,
    input  regAddr_t   fwdExecDest,
    input  regAddr_t   fwdResDest,
    input  regData_t   fwdExecData,
    input  regData_t   fwdResData,
    output logic       decValid,
    output aluOp_t     decOp,
    output regAddr_t   decDest,
    output regData_t   decA,
    output regData_t   decB,
    output shamt_t     decShamt,
    output regData_t   decImm,
    output pc_t        decPc,
    output logic       decBranchTaken
);

    localparam int PtrW = $clog2(`QUEUE_DEPTH);
    localparam int CntW = $clog2(`QUEUE_DEPTH + 1);

    instrWord_t      qWord [`QUEUE_DEPTH];
    pc_t             qPc [`QUEUE_DEPTH];
    logic [PtrW-1:0] wrPtr;
    logic [PtrW-1:0] rdPtr;
    logic [CntW-1:0] qCount;
    logic            qEmpty;
    logic            pop;
    instrWord_t      headWord;
    aluOp_t          op;
    regAddr_t        rs;
    regAddr_t        rt;
    regAddr_t        dest;
    shamt_t          shamt;
    regData_t        imm;
    regData_t        opA;
    regData_t        opB;
    logic            taken;

    function automatic logic [PtrW-1:0] nextPtr(logic [PtrW-1:0] ptr);
        return (ptr == PtrW'(`QUEUE_DEPTH - 1)) ? '0 : ptr + PtrW'(1);
    endfunction

    assign qEmpty = (qCount == '0);
    assign pop    = !stall && !qEmpty;

    // Queue storage is written on every push
    always_ff @(posedge clk) begin
        if (instrValid) begin
            qWord[wrPtr] <= instrWord;
            qPc[wrPtr]   <= instrPc;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            wrPtr             <= '0;
            rdPtr             <= '0;
            qCount            <= '0;
            instrCreditReturn <= 1'b0;
        end else begin
            if (instrValid) wrPtr <= nextPtr(wrPtr);
            if (pop) rdPtr <= nextPtr(rdPtr);
            qCount            <= qCount + CntW'(instrValid) - CntW'(pop);
            // One credit back per instruction handed to decode
            instrCreditReturn <= pop;
        end
    end

    // An empty queue decodes the zero word as a bubble
    assign headWord = qEmpty ? '0 : qWord[rdPtr];

    instrDecode uDecode (
        .instrWord (headWord),
        .op        (op),
        .rs        (rs),
        .rt        (rt),
        .dest      (dest),
        .shamt     (shamt),
        .imm       (imm)
    );

    assign rdAddrA = rs;
    assign rdAddrB = rt;

    // Youngest producer wins
    assign opA = (rs != '0 && rs == fwdExecDest) ? fwdExecData :
                 (rs != '0 && rs == fwdResDest)  ? fwdResData  : rdDataA;
    assign opB = (rt != '0 && rt == fwdExecDest) ? fwdExecData :
                 (rt != '0 && rt == fwdResDest)  ? fwdResData  : rdDataB;

    always_comb begin
        case (op)
            opBeq:   taken = (opA == opB);
            opBne:   taken = (opA != opB);
            opBlez:  taken = opA[31] || (opA == '0);
            opBgtz:  taken = !opA[31] && (opA != '0);
            opBltz:  taken = opA[31];
            opBgez:  taken = !opA[31];
            default: taken = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            decValid       <= 1'b0;
            decOp          <= opNop;
            decDest        <= '0;
            decBranchTaken <= 1'b0;
        end else if (!stall) begin
            decValid       <= !qEmpty;
            decOp          <= op;
            decDest        <= dest;
            decBranchTaken <= taken;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            decA     <= opA;
            decB     <= opB;
            decShamt <= shamt;
            decImm   <= imm;
            decPc    <= qPc[rdPtr];
        end
    end

    // Source must hold back while it has no credits
    assert property (@(posedge clk) disable iff (!rstN)
        instrValid |-> qCount != CntW'(`QUEUE_DEPTH))
        else $error("Instruction pushed into a full queue");

endmodule

//--- hw/executeStage.sv
// Execute stage
// ALU with register or immediate operand, link value for jal,
// forwarding of the live result and the execute register

module executeStage import mipsCorePkg::*; (
    input  logic     clk,
    input  logic     rstN,
    input  logic     stall,
    input  logic     decValid,
    input  aluOp_t   decOp,
    input  regAddr_t decDest,
    input  regData_t decA,
    input  regData_t decB,
    input  shamt_t   decShamt,
    input  regData_t decImm,
    input  pc_t      decPc,
    input  logic     decBranchTaken,
    output regAddr_t fwdExecDest,
    output regData_t fwdExecData,
    output logic     exValid,
    output regAddr_t exDest,
    output regData_t exData,
    output pc_t      exPc,
    output logic     exBranchTaken
);

    regData_t opB;
    regData_t aluResult;
    regData_t result;

    assign opB = (decOp inside {opAddiu, opAndi, opOri, opXori, opSlti, opSltiu}) ?
                 decImm : decB;

    always_comb begin
        case (decOp)
            opAddu, opAddiu: aluResult = decA + opB;
            opSubu:          aluResult = decA - opB;
            opAnd, opAndi:   aluResult = decA & opB;
            opOr, opOri:     aluResult = decA | opB;
            opXor, opXori:   aluResult = decA ^ opB;
            opNor:           aluResult = ~(decA | opB);
            opSlt, opSlti:   aluResult = regData_t'($signed(decA) < $signed(opB));
            opSltu, opSltiu: aluResult = regData_t'(decA < opB);
            opSll:           aluResult = decB << decShamt;
            opSrl:           aluResult = decB >> decShamt;
            opSra:           aluResult = regData_t'($signed(decB) >>> decShamt);
            opLui:           aluResult = decImm;
            // Return address skips the delay slot
            opJal:           aluResult = decPc + 32'd8;
            default:         aluResult = '0;
        endcase
    end

    // Nothing lands in register 0, so its result reads as zero
    assign result = (decDest == '0) ? '0 : aluResult;

    assign fwdExecDest = decDest;
    assign fwdExecData = result;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            exValid       <= 1'b0;
            exDest        <= '0;
            exBranchTaken <= 1'b0;
        end else if (!stall) begin
            exValid       <= decValid;
            exDest        <= decDest;
            exBranchTaken <= decBranchTaken;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            exData <= result;
            exPc   <= decPc;
        end
    end

endmodule

//--- hw/resultStage.sv
// Result stage
// Retire register, retire credit counter and stall,
// register write-back in the retire cycle

`include "mipsCore_macros.svh"

module resultStage import mipsCorePkg::*; (
    input  logic     clk,
    input  logic     rstN,
    input  logic     exValid,
    input  regAddr_t exDest,
    input  regData_t exData,
    input  pc_t      exPc,
    input  logic     exBranchTaken,
    input  logic     retireCreditReturn,
    output logic     stall,
    output logic     regWrite,
    output regAddr_t wrAddr,
    output regData_t wrData,
    output logic     retireValid,
    output pc_t      retirePc,
    output regAddr_t retireDest,
    output regData_t retireData,
    output logic     retireBranchTaken
);

    localparam int CntW = $clog2(`RETIRE_CREDITS + 1);

    logic [CntW-1:0] creditCnt;

    // Hold when the retire now in flight uses the last credit
    assign stall = (creditCnt == CntW'(retireValid));

    always_ff @(posedge clk) begin
        if (!rstN) begin
            creditCnt <= CntW'(`RETIRE_CREDITS);
        end else begin
            creditCnt <= creditCnt - CntW'(retireValid) + CntW'(retireCreditReturn);
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            retireValid       <= 1'b0;
            retireDest        <= '0;
            retireBranchTaken <= 1'b0;
        end else if (!stall) begin
            retireValid       <= exValid;
            retireDest        <= exDest;
            retireBranchTaken <= exBranchTaken;
        end else begin
            retireValid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            retireData <= exData;
            retirePc   <= exPc;
        end
    end

    assign regWrite = retireValid && (retireDest != '0);
    assign wrAddr   = retireDest;
    assign wrData   = retireData;

    // Consumer returns no more credits than it was given
    assert property (@(posedge clk) disable iff (!rstN)
        creditCnt <= CntW'(`RETIRE_CREDITS))
        else $error("Retire credit count above its limit");

    assert property (@(posedge clk) disable iff (!rstN)
        retireValid |-> creditCnt != '0)
        else $error("Retire issued without a credit");

endmodule

//--- hw/mipsCore.sv
// Three-stage integer core
// Decode, execute and result stages around a shared register
// file, with credit flow control on both the input and retire sides

module mipsCore import mipsCorePkg::*; (
    input  logic       clk,
    input  logic       rstN,
    input  logic       instrValid,
    input  instrWord_t instrWord,
    input  pc_t        instrPc,
    output logic       instrCreditReturn,
    input  logic       retireCreditReturn,
    output logic       retireValid,
    output pc_t        retirePc,
    output regAddr_t   retireDest,
    output regData_t   retireData,
    output logic       retireBranchTaken
);

    logic     stall;
    regAddr_t rdAddrA;
    regAddr_t rdAddrB;
    regData_t rdDataA;
    regData_t rdDataB;
    logic     regWrite;
    regAddr_t wrAddr;
    regData_t wrData;
    regAddr_t fwdExecDest;
    regData_t fwdExecData;

    // Decode register
    logic     decValid;
    aluOp_t   decOp;
    regAddr_t decDest;
    regData_t decA;
    regData_t decB;
    shamt_t   decShamt;
    regData_t decImm;
    pc_t      decPc;
    logic     decBranchTaken;

    // Execute register, also the second forwarding source
    logic     exValid;
    regAddr_t exDest;
    regData_t exData;
    pc_t      exPc;
    logic     exBranchTaken;

    decodeStage uDecodeStage (
        .clk               (clk),
        .rstN              (rstN),
        .instrValid        (instrValid),
        .instrWord         (instrWord),
        .instrPc           (instrPc),
        .instrCreditReturn (instrCreditReturn),
        .stall             (stall),
        .rdAddrA           (rdAddrA),
        .rdAddrB           (rdAddrB),
        .rdDataA           (rdDataA),
        .rdDataB           (rdDataB),
        .fwdExecDest       (fwdExecDest),
        .fwdResDest        (exDest),
        .fwdExecData       (fwdExecData),
        .fwdResData        (exData),
        .decValid          (decValid),
        .decOp             (decOp),
        .decDest           (decDest),
        .decA              (decA),
        .decB              (decB),
        .decShamt          (decShamt),
        .decImm            (decImm),
        .decPc             (decPc),
        .decBranchTaken    (decBranchTaken)
    );

    executeStage uExecuteStage (
        .clk            (clk),
        .rstN           (rstN),
        .stall          (stall),
        .decValid       (decValid),
        .decOp          (decOp),
        .decDest        (decDest),
        .decA           (decA),
        .decB           (decB),
        .decShamt       (decShamt),
        .decImm         (decImm),
        .decPc          (decPc),
        .decBranchTaken (decBranchTaken),
        .fwdExecDest    (fwdExecDest),
        .fwdExecData    (fwdExecData),
        .exValid        (exValid),
        .exDest         (exDest),
        .exData         (exData),
        .exPc           (exPc),
        .exBranchTaken  (exBranchTaken)
    );

    resultStage uResultStage (
        .clk                (clk),
        .rstN               (rstN),
        .exValid            (exValid),
        .exDest             (exDest),
        .exData             (exData),
        .exPc               (exPc),
        .exBranchTaken      (exBranchTaken),
        .retireCreditReturn (retireCreditReturn),
        .stall              (stall),
        .regWrite           (regWrite),
        .wrAddr             (wrAddr),
        .wrData             (wrData),
        .retireValid        (retireValid),
        .retirePc           (retirePc),
        .retireDest         (retireDest),
        .retireData         (retireData),
        .retireBranchTaken  (retireBranchTaken)
    );

    regFile uRegFile (
        .clk      (clk),
        .rstN     (rstN),
        .rdAddrA  (rdAddrA),
        .rdAddrB  (rdAddrB),
        .rdDataA  (rdDataA),
        .rdDataB  (rdDataB),
        .regWrite (regWrite),
        .wrAddr   (wrAddr),
        .wrData   (wrData)
    );

endmodule

//--- dv/mipsCoreTbTable.svh
// Instruction table for the core testbench
// Columns: instruction word, PC, expected destination, expected data,
// expected branch taken flag. Registers hold zero after reset

`ifndef MIPS_CORE_TB_TABLE_SVH
`define MIPS_CORE_TB_TABLE_SVH

localparam int NumRows = 40;

task automatic loadTable();
    // Dependent ALU chain, results feed the next rows directly
    addRow(iTypeWord(6'h09, 5'd0, 5'd1, 16'h0005), 32'h100, 5'd1, 32'h0000_0005, 1'b0);
    addRow(iTypeWord(6'h09, 5'd1, 5'd2, 16'hfffd), 32'h104, 5'd2, 32'h0000_0002, 1'b0);
    addRow(rTypeWord(6'h21, 5'd1, 5'd2, 5'd3, 5'd0), 32'h108, 5'd3, 32'h0000_0007, 1'b0);
    addRow(rTypeWord(6'h23, 5'd2, 5'd3, 5'd4, 5'd0), 32'h10c, 5'd4, 32'hffff_fffb, 1'b0);
    addRow(iTypeWord(6'h0f, 5'd0, 5'd5, 16'h8001), 32'h110, 5'd5, 32'h8001_0000, 1'b0);
    addRow(iTypeWord(6'h0d, 5'd5, 5'd5, 16'h00f0), 32'h114, 5'd5, 32'h8001_00f0, 1'b0);
    addRow(rTypeWord(6'h24, 5'd5, 5'd4, 5'd6, 5'd0), 32'h118, 5'd6, 32'h8001_00f0, 1'b0);
    addRow(rTypeWord(6'h25, 5'd1, 5'd3, 5'd7, 5'd0), 32'h11c, 5'd7, 32'h0000_0007, 1'b0);
    addRow(rTypeWord(6'h26, 5'd5, 5'd6, 5'd8, 5'd0), 32'h120, 5'd8, 32'h0000_0000, 1'b0);
    addRow(rTypeWord(6'h27, 5'd1, 5'd0, 5'd9, 5'd0), 32'h124, 5'd9, 32'hffff_fffa, 1'b0);
    addRow(rTypeWord(6'h2a, 5'd4, 5'd1, 5'd10, 5'd0), 32'h128, 5'd10, 32'h0000_0001, 1'b0);
    addRow(rTypeWord(6'h2b, 5'd4, 5'd1, 5'd11, 5'd0), 32'h12c, 5'd11, 32'h0000_0000, 1'b0);
    // Shifts take rt and shamt
    addRow(rTypeWord(6'h00, 5'd0, 5'd1, 5'd12, 5'd4), 32'h130, 5'd12, 32'h0000_0050, 1'b0);
    addRow(rTypeWord(6'h02, 5'd0, 5'd5, 5'd13, 5'd8), 32'h134, 5'd13, 32'h0080_0100, 1'b0);
    addRow(rTypeWord(6'h03, 5'd0, 5'd5, 5'd14, 5'd8), 32'h138, 5'd14, 32'hff80_0100, 1'b0);
    addRow(iTypeWord(6'h0c, 5'd9, 5'd15, 16'hff0f), 32'h13c, 5'd15, 32'h0000_ff0a, 1'b0);
    addRow(iTypeWord(6'h0e, 5'd15, 5'd16, 16'h00ff), 32'h140, 5'd16, 32'h0000_fff5, 1'b0);
    addRow(iTypeWord(6'h0a, 5'd4, 5'd17, 16'hfffb), 32'h144, 5'd17, 32'h0000_0000, 1'b0);
    addRow(iTypeWord(6'h0b, 5'd1, 5'd18, 16'hffff), 32'h148, 5'd18, 32'h0000_0001, 1'b0);
    // Branches retire no data, only the taken flag
    addRow(iTypeWord(6'h04, 5'd1, 5'd7, 16'h0010), 32'h14c, 5'd0, 32'h0000_0000, 1'b0);
    addRow(iTypeWord(6'h05, 5'd3, 5'd7, 16'h0010), 32'h150, 5'd0, 32'h0000_0000, 1'b0);
    addRow(iTypeWord(6'h09, 5'd0, 5'd19, 16'hffff), 32'h154, 5'd19, 32'hffff_ffff, 1'b0);
    addRow(iTypeWord(6'h01, 5'd19, 5'd0, 16'h0008), 32'h158, 5'd0, 32'h0000_0000, 1'b1);
    addRow(iTypeWord(6'h01, 5'd19, 5'd1, 16'h0008), 32'h15c, 5'd0, 32'h0000_0000, 1'b0);
    addRow(iTypeWord(6'h06, 5'd0, 5'd0, 16'h0008), 32'h160, 5'd0, 32'h0000_0000, 1'b1);
    addRow(iTypeWord(6'h07, 5'd1, 5'd0, 16'h0008), 32'h164, 5'd0, 32'h0000_0000, 1'b1);
    addRow(iTypeWord(6'h04, 5'd3, 5'd7, 16'h0008), 32'h168, 5'd0, 32'h0000_0000, 1'b1);
    addRow(iTypeWord(6'h05, 5'd4, 5'd1, 16'h0008), 32'h16c, 5'd0, 32'h0000_0000, 1'b1);
    // Link register written by jal and read back at once
    addRow(iTypeWord(6'h03, 5'd0, 5'd0, 16'h0040), 32'h170, 5'd31, 32'h0000_0178, 1'b0);
    addRow(rTypeWord(6'h21, 5'd31, 5'd0, 5'd20, 5'd0), 32'h174, 5'd20, 32'h0000_0178, 1'b0);
    // No-ops and register 0
    addRow(32'h0000_0000, 32'h178, 5'd0, 32'h0000_0000, 1'b0);
    addRow(iTypeWord(6'h3f, 5'd1, 5'd2, 16'h1234), 32'h17c, 5'd0, 32'h0000_0000, 1'b0);
    addRow(iTypeWord(6'h09, 5'd1, 5'd0, 16'h0010), 32'h180, 5'd0, 32'h0000_0000, 1'b0);
    addRow(rTypeWord(6'h21, 5'd0, 5'd1, 5'd21, 5'd0), 32'h184, 5'd21, 32'h0000_0005, 1'b0);
    addRow(iTypeWord(6'h09, 5'd22, 5'd22, 16'h0001), 32'h188, 5'd22, 32'h0000_0001, 1'b0);
    addRow(iTypeWord(6'h09, 5'd22, 5'd22, 16'h0001), 32'h18c, 5'd22, 32'h0000_0002, 1'b0);
    addRow(iTypeWord(6'h09, 5'd22, 5'd22, 16'h0001), 32'h190, 5'd22, 32'h0000_0003, 1'b0);
    addRow(rTypeWord(6'h21, 5'd22, 5'd22, 5'd23, 5'd0), 32'h194, 5'd23, 32'h0000_0006, 1'b0);
    addRow(rTypeWord(6'h23, 5'd23, 5'd22, 5'd24, 5'd0), 32'h198, 5'd24, 32'h0000_0003, 1'b0);
    addRow(rTypeWord(6'h03, 5'd0, 5'd4, 5'd25, 5'd1), 32'h19c, 5'd25, 32'hffff_fffd, 1'b0);
endtask

`endif

//--- dv/mipsCoreTb.sv
// Testbench for the three-stage integer core
// Sends a table of instructions under input credits, absorbs retires
// with randomly delayed credit returns and checks every retire in order

`include "mipsCore_macros.svh"

module mipsCoreTb import mipsCorePkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int ClkPeriod      = 20;
    localparam int ResetCycles    = 10;
    localparam int CyclesPerRow   = 60;
    localparam int WithholdAt     = 8;
    localparam int WithholdCycles = 60;
    localparam int DrainCycles    = 20;

    logic       clk;
    logic       rstN;
    logic       instrValid;
    instrWord_t instrWord;
    pc_t        instrPc;
    logic       instrCreditReturn;
    logic       retireCreditReturn;
    logic       retireValid;
    pc_t        retirePc;
    regAddr_t   retireDest;
    regData_t   retireData;
    logic       retireBranchTaken;

    // Table columns
    instrWord_t tblWord [$];
    pc_t        tblPc [$];
    regAddr_t   tblDest [$];
    regData_t   tblData [$];
    logic       tblTaken [$];

    logic [31:0] rngState;
    int srcCredits;
    int sent;
    int retired;
    int owed;
    int withholdLeft;
    int creditReturns;
    int errors;
    int passedRows;
    int failedRows;
    logic creditsRanOut;

    mipsCore u_dut (
        .clk                (clk),
        .rstN               (rstN),
        .instrValid         (instrValid),
        .instrWord          (instrWord),
        .instrPc            (instrPc),
        .instrCreditReturn  (instrCreditReturn),
        .retireCreditReturn (retireCreditReturn),
        .retireValid        (retireValid),
        .retirePc           (retirePc),
        .retireDest         (retireDest),
        .retireData         (retireData),
        .retireBranchTaken  (retireBranchTaken)
    );

    initial clk = 1'b0;
    always #(ClkPeriod / 2) clk = ~clk;

    function automatic logic [31:0] xorshift(logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] nextRandom();
        rngState = xorshift(rngState);
        return rngState;
    endfunction

    function automatic instrWord_t rTypeWord(logic [5:0] funct, regAddr_t rs, regAddr_t rt,
                                             regAddr_t rd, shamt_t sh);
        return {6'b000000, rs, rt, rd, sh, funct};
    endfunction

    function automatic instrWord_t iTypeWord(logic [5:0] opc, regAddr_t rs, regAddr_t rt,
                                             logic [15:0] imm);
        return {opc, rs, rt, imm};
    endfunction

    task automatic addRow(instrWord_t word, pc_t pc, regAddr_t dest, regData_t data,
                          logic taken);
        tblWord.push_back(word);
        tblPc.push_back(pc);
        tblDest.push_back(dest);
        tblData.push_back(data);
        tblTaken.push_back(taken);
    endtask

    `include "mipsCoreTbTable.svh"

    task automatic checkPc(string what, pc_t got, pc_t exp);
        if (got !== exp) begin
            $display("error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic checkReg(string what, regAddr_t got, regAddr_t exp);
        if (got !== exp) begin
            $display("error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic checkData(string what, regData_t got, regData_t exp);
        if (got !== exp) begin
            $display("error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic checkFlag(string what, logic got, logic exp);
        if (got !== exp) begin
            $display("error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
            errors++;
        end
    endtask

    // Source side runs once per falling edge
    task automatic driveSource();
        logic [31:0] r;
        r = nextRandom();
        if (instrCreditReturn) begin
            srcCredits++;
            creditReturns++;
        end
        if (srcCredits > `QUEUE_DEPTH) begin
            $display("Source got back more input credits than the queue has slots");
            errors++;
        end
        // Idle gap on about one cycle in four
        if (sent < tblWord.size() && srcCredits > 0 && r[1:0] != 2'b00) begin
            instrValid = 1'b1;
            instrWord  = tblWord[sent];
            instrPc    = tblPc[sent];
            srcCredits--;
            sent++;
        end else begin
            instrValid = 1'b0;
        end
        if (srcCredits == 0) creditsRanOut = 1'b1;
    endtask

    // Consumer side and retire monitor run after the source
    task automatic watchRetire();
        logic [31:0] r;
        int errBefore;
        r = nextRandom();
        if (retireValid) begin
            if (owed >= `RETIRE_CREDITS) begin
                $display("Retire at %0t ns arrived with no free consumer slot", $time);
                errors++;
            end
            owed++;
            if (retired >= tblWord.size()) begin
                $display("Retire at %0t ns has no matching table row", $time);
                errors++;
            end else begin
                errBefore = errors;
                checkPc($sformatf("row %0d pc", retired), retirePc, tblPc[retired]);
                checkReg($sformatf("row %0d dest", retired), retireDest, tblDest[retired]);
                checkData($sformatf("row %0d data", retired), retireData, tblData[retired]);
                checkFlag($sformatf("row %0d taken", retired), retireBranchTaken,
                          tblTaken[retired]);
                if (errors == errBefore) begin
                    passedRows++;
                    $display("row %0d pc %h: pass", retired, tblPc[retired]);
                end else begin
                    failedRows++;
                    $display("row %0d pc %h: fail", retired, tblPc[retired]);
                end
            end
            retired++;
            if (retired == WithholdAt) withholdLeft = WithholdCycles;
        end
        if (withholdLeft > 0) begin
            withholdLeft--;
            retireCreditReturn = 1'b0;
        end else if (owed > 0 && r[0]) begin
            retireCreditReturn = 1'b1;
            owed--;
        end else begin
            retireCreditReturn = 1'b0;
        end
    endtask

    initial begin
        rngState           = 32'h4cfe_504b;
        rstN               = 1'b0;
        instrValid         = 1'b0;
        instrWord          = '0;
        instrPc            = '0;
        retireCreditReturn = 1'b0;
        srcCredits         = `QUEUE_DEPTH;
        sent               = 0;
        retired            = 0;
        owed               = 0;
        withholdLeft       = 0;
        creditReturns      = 0;
        errors             = 0;
        passedRows         = 0;
        failedRows         = 0;
        creditsRanOut      = 1'b0;
        loadTable();
        repeat (ResetCycles) @(negedge clk);
        rstN = 1'b1;
        while (retired < tblWord.size()) begin
            @(negedge clk);
            driveSource();
            watchRetire();
        end
        // Catch stray retires and the last credit returns
        repeat (DrainCycles) begin
            @(negedge clk);
            driveSource();
            watchRetire();
        end
        if (creditReturns != sent) begin
            $display("Core returned %0d input credits for %0d instructions",
                     creditReturns, sent);
            errors++;
        end
        if (!creditsRanOut) begin
            $display("Retire back-pressure never used up the source's input credits");
            errors++;
        end
        $display("rows passed %0d, rows failed %0d, errors %0d, sent %0d, credits back %0d",
                 passedRows, failedRows, errors, sent, creditReturns);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    initial begin
        #(NumRows * CyclesPerRow * ClkPeriod);
        $display("Watchdog expired at %0t ns, retires stopped after %0d of %0d rows",
                 $time, retired, NumRows);
        $display("Test FAILED");
        $finish;
    end

endmodule

//--- mipsCore.f
+incdir+hw
+incdir+dv
hw/mipsCorePkg.sv
hw/instrDecode.sv
hw/regFile.sv
hw/decodeStage.sv
hw/executeStage.sv
hw/resultStage.sv
hw/mipsCore.sv
dv/mipsCoreTb.sv

//--- run.sh
#!/bin/sh
# Builds the core testbench with Verilator, runs it and scans the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module mipsCoreTb -f mipsCore.f -o mipsCoreSim \
    && ./obj_dir/mipsCoreSim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "Test FAILED" sim.log && exit 1 || exit 0
